/* Makefile */
VERILATOR ?= verilator
TOP       ?= rv32_alu_core_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(BUILD_DIR)

/* common/decode_if.sv */
`timescale 1ns/100ps

// Decoded instruction, decode to operand fetch
interface decode_if;
  import rv32_pipe_pkg::*;

  logic      valid;
  alu_op_e   op;
  reg_addr_t rd;
  reg_addr_t rs1;
  reg_addr_t rs2;
  logic      use_imm;
  word_t     imm;

  modport producer (output valid, op, rd, rs1, rs2, use_imm, imm);
  modport consumer (input valid, op, rd, rs1, rs2, use_imm, imm);

endinterface

/* common/issue_if.sv */
`timescale 1ns/100ps

// Operands and operation, operand fetch to execute
interface issue_if;
  import rv32_pipe_pkg::*;

  logic      valid;
  alu_op_e   op;
  reg_addr_t rd;
  reg_addr_t rs1;
  reg_addr_t rs2;
  word_t     operand_a;
  word_t     operand_b;
  logic      use_imm;

  modport producer (output valid, op, rd, rs1, rs2, operand_a, operand_b, use_imm);
  modport consumer (input valid, op, rd, rs1, rs2, operand_a, operand_b, use_imm);

endinterface

/* common/rv32_isa_pkg.sv */
package rv32_isa_pkg;

  //////////////////////////////////////////////////////////////////////
  // Major opcodes
  //////////////////////////////////////////////////////////////////////

  localparam logic [6:0] opcode_op     = 7'b0110011;
  localparam logic [6:0] opcode_op_imm = 7'b0010011;
  localparam logic [6:0] opcode_lui    = 7'b0110111;

  //////////////////////////////////////////////////////////////////////
  // Function codes, shared by OP and OP-IMM
  //////////////////////////////////////////////////////////////////////

  localparam logic [2:0] funct3_add  = 3'b000;
  localparam logic [2:0] funct3_sll  = 3'b001;
  localparam logic [2:0] funct3_slt  = 3'b010;
  localparam logic [2:0] funct3_sltu = 3'b011;
  localparam logic [2:0] funct3_xor  = 3'b100;
  // Covers both srl and sra
  localparam logic [2:0] funct3_sr   = 3'b101;
  localparam logic [2:0] funct3_or   = 3'b110;
  localparam logic [2:0] funct3_and  = 3'b111;

  // Instruction bit that turns add into sub and srl into sra
  localparam int funct7_alt_bit = 30;

  //////////////////////////////////////////////////////////////////////
  // Field positions
  //////////////////////////////////////////////////////////////////////

  localparam int rd_lsb  = 7;
  localparam int rs1_lsb = 15;
  localparam int rs2_lsb = 20;

endpackage

/* common/rv32_pipe_pkg.sv */
package rv32_pipe_pkg;

  localparam int xlen     = 32;
  localparam int reg_bits = 5;
  localparam int num_regs = 32;

  typedef logic [xlen-1:0]     word_t;
  typedef logic [reg_bits-1:0] reg_addr_t;

  // ALU operations, pass_b serves LUI
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b
  } alu_op_e;

  // Edges from instruction strobe to writeback strobe
  localparam int pipe_latency = 3;

endpackage

/* decode/rv32_decode.sv */
`timescale 1ns/100ps

module rv32_decode (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 instr_valid_i,
  input  rv32_pipe_pkg::word_t instr_i,
  output logic                 illegal_o,
  decode_if.producer           dec
);
  import rv32_isa_pkg::*;
  import rv32_pipe_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       alt;
  logic [5:0] funct7_rest;
  logic       is_op;
  logic       alt_ok;
  logic       needs_funct7;
  logic       funct7_ok;
  logic       legal;
  logic       use_imm_next;
  word_t      imm_next;
  alu_op_e    op_next;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign alt    = instr_i[funct7_alt_bit];
  // funct7 bits other than the alternate bit
  assign funct7_rest = {instr_i[31], instr_i[29:25]};

  assign is_op = (opcode == opcode_op);

  // Alternate bit only means something for sub and sra
  assign alt_ok = (funct3 == funct3_sr) || (is_op && funct3 == funct3_add);
  // OP-IMM only carries a funct7 for shifts
  assign needs_funct7 = funct3 == funct3_sll || funct3 == funct3_sr;
  assign funct7_ok = (funct7_rest == '0) && (!alt || alt_ok);

  //////////////////////////////////////////////////////////////////////
  // Operation and legality
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (funct3)
      funct3_add:  op_next = (is_op && alt) ? alu_sub : alu_add;
      funct3_sll:  op_next = alu_sll;
      funct3_slt:  op_next = alu_slt;
      funct3_sltu: op_next = alu_sltu;
      funct3_xor:  op_next = alu_xor;
      funct3_sr:   op_next = alt ? alu_sra : alu_srl;
      funct3_or:   op_next = alu_or;
      default:     op_next = alu_and;
    endcase

    // Sign-extended I immediate by default
    imm_next     = {{(xlen-12){instr_i[31]}}, instr_i[31:20]};
    use_imm_next = 1'b1;

    case (opcode)
      opcode_op: begin
        legal        = funct7_ok;
        use_imm_next = 1'b0;
      end
      opcode_op_imm: begin
        legal = !needs_funct7 || funct7_ok;
      end
      opcode_lui: begin
        legal    = 1'b1;
        op_next  = alu_pass_b;
        imm_next = {instr_i[31:12], 12'b0};
      end
      default: begin
        legal = 1'b0;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Stage register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      dec.valid <= 1'b0;
      illegal_o <= 1'b0;
    end else begin
      dec.valid <= instr_valid_i && legal;
      illegal_o <= instr_valid_i && !legal;
    end
  end

  always_ff @(posedge clk_i) begin
    if (instr_valid_i) begin
      dec.op      <= op_next;
      dec.rd      <= instr_i[rd_lsb +: reg_bits];
      dec.rs1     <= instr_i[rs1_lsb +: reg_bits];
      dec.rs2     <= instr_i[rs2_lsb +: reg_bits];
      dec.use_imm <= use_imm_next;
      dec.imm     <= imm_next;
    end
  end

endmodule

/* execute/rv32_execute.sv */
`timescale 1ns/100ps

module rv32_execute (
  input  logic                      clk_i,
  input  logic                      reset_i,
  issue_if.consumer                 iss,
  output logic                      wb_we_o,
  output rv32_pipe_pkg::reg_addr_t  wb_rd_o,
  output rv32_pipe_pkg::word_t      wb_data_o
);
  import rv32_pipe_pkg::*;

  logic       fwd_a;
  logic       fwd_b;
  word_t      src_a;
  word_t      src_b;
  logic [4:0] shamt;
  word_t      result;

  //////////////////////////////////////////////////////////////////////
  // Forwarding from the writeback register
  //////////////////////////////////////////////////////////////////////

  // Held result counts only while its write strobe is up
  assign fwd_a = wb_we_o && (iss.rs1 == wb_rd_o);
  // Never overwrite an immediate
  assign fwd_b = wb_we_o && !iss.use_imm && (iss.rs2 == wb_rd_o);

  assign src_a = fwd_a ? wb_data_o : iss.operand_a;
  assign src_b = fwd_b ? wb_data_o : iss.operand_b;
  assign shamt = src_b[4:0];

  //////////////////////////////////////////////////////////////////////
  // ALU
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (iss.op)
      alu_add:  result = src_a + src_b;
      alu_sub:  result = src_a - src_b;
      alu_sll:  result = src_a << shamt;
      alu_slt:  result = {{(xlen-1){1'b0}}, $signed(src_a) < $signed(src_b)};
      alu_sltu: result = {{(xlen-1){1'b0}}, src_a < src_b};
      alu_xor:  result = src_a ^ src_b;
      alu_srl:  result = src_a >> shamt;
      // Arithmetic shift keeps the sign
      alu_sra:  result = word_t'($signed(src_a) >>> shamt);
      alu_or:   result = src_a | src_b;
      alu_and:  result = src_a & src_b;
      default:  result = src_b;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Writeback register
  //////////////////////////////////////////////////////////////////////

  // Writes to x0 are dropped here and nowhere else
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wb_we_o <= 1'b0;
    end else begin
      wb_we_o <= iss.valid && (iss.rd != '0);
    end
  end

  always_ff @(posedge clk_i) begin
    if (iss.valid) begin
      wb_rd_o   <= iss.rd;
      wb_data_o <= result;
    end
  end

endmodule

/* regfile/rv32_operand_fetch.sv */
`timescale 1ns/100ps

module rv32_operand_fetch (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     wb_we_i,
  input  rv32_pipe_pkg::reg_addr_t wb_rd_i,
  input  rv32_pipe_pkg::word_t     wb_data_i,
  decode_if.consumer               dec,
  issue_if.producer                iss
);
  import rv32_pipe_pkg::*;

  word_t regs [num_regs];
  word_t rs1_data;
  word_t rs2_data;

  // x0 stays zero, execute never writes it
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_we_i) begin
      regs[wb_rd_i] <= wb_data_i;
    end
  end

  // Write-through for the instruction two ahead
  assign rs1_data = (wb_we_i && wb_rd_i == dec.rs1) ? wb_data_i : regs[dec.rs1];
  assign rs2_data = (wb_we_i && wb_rd_i == dec.rs2) ? wb_data_i : regs[dec.rs2];

  //////////////////////////////////////////////////////////////////////
  // Stage register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      iss.valid <= 1'b0;
    end else begin
      iss.valid <= dec.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (dec.valid) begin
      iss.op        <= dec.op;
      iss.rd        <= dec.rd;
      iss.rs1       <= dec.rs1;
      iss.rs2       <= dec.rs2;
      iss.use_imm   <= dec.use_imm;
      iss.operand_a <= rs1_data;
      iss.operand_b <= dec.use_imm ? dec.imm : rs2_data;
    end
  end

endmodule

/* sources.f */
common/rv32_isa_pkg.sv
common/rv32_pipe_pkg.sv
common/decode_if.sv
common/issue_if.sv
decode/rv32_decode.sv
regfile/rv32_operand_fetch.sv
execute/rv32_execute.sv
src/rv32_alu_core.sv
test/rv32_alu_core_props.sv
test/rv32_alu_core_tb.sv

/* src/rv32_alu_core.sv */
`timescale 1ns/100ps

module rv32_alu_core (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      instr_valid_i,
  input  rv32_pipe_pkg::word_t      instr_i,
  output logic                      wb_valid_o,
  output rv32_pipe_pkg::reg_addr_t  wb_rd_o,
  output rv32_pipe_pkg::word_t      wb_data_o,
  output logic                      illegal_o
);

  decode_if dec_bus ();
  issue_if  iss_bus ();

  //////////////////////////////////////////////////////////////////////
  // Stage 1: decode
  //////////////////////////////////////////////////////////////////////

  rv32_decode u_decode (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .illegal_o     (illegal_o),
    .dec           (dec_bus.producer)
  );

  //////////////////////////////////////////////////////////////////////
  // Stage 2: register file and operand fetch
  //////////////////////////////////////////////////////////////////////

  // Writeback strobe doubles as the register file write enable
  rv32_operand_fetch u_operand_fetch (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .wb_we_i   (wb_valid_o),
    .wb_rd_i   (wb_rd_o),
    .wb_data_i (wb_data_o),
    .dec       (dec_bus.consumer),
    .iss       (iss_bus.producer)
  );

  //////////////////////////////////////////////////////////////////////
  // Stage 3: execute and writeback
  //////////////////////////////////////////////////////////////////////

  rv32_execute u_execute (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .iss       (iss_bus.consumer),
    .wb_we_o   (wb_valid_o),
    .wb_rd_o   (wb_rd_o),
    .wb_data_o (wb_data_o)
  );

endmodule

/* test/rv32_alu_core_props.sv */
`timescale 1ns/100ps

module rv32_alu_core_props (
  input logic                     clk_i,
  input logic                     reset_i,
  input logic                     instr_valid_i,
  input rv32_pipe_pkg::word_t     instr_i,
  input logic                     wb_valid_o,
  input rv32_pipe_pkg::reg_addr_t wb_rd_o,
  input logic                     illegal_o
);
  import rv32_isa_pkg::*;
  import rv32_pipe_pkg::*;

  logic writes_rd;

  assign writes_rd = instr_valid_i && (instr_i[rd_lsb +: reg_bits] != '0);

  // x0 is never the target of a writeback
  wb_rd_nonzero: assert property (@(posedge clk_i) disable iff (reset_i)
    wb_valid_o |-> wb_rd_o != '0)
    else $error("writeback strobe carries rd zero");

  // Both strobes low in the cycle after a reset edge
  reset_quiet: assert property (@(posedge clk_i) reset_i |=> !wb_valid_o && !illegal_o)
    else $error("output strobe high right after reset");

  // Legal instruction with nonzero rd reaches writeback after the pipeline latency
  wb_latency: assert property (@(posedge clk_i) disable iff (reset_i)
    $past(writes_rd, pipe_latency) && !$past(illegal_o, pipe_latency - 1) |-> wb_valid_o)
    else $error("writeback strobe missing at pipeline latency");

endmodule

bind rv32_alu_core rv32_alu_core_props u_props (
  .clk_i         (clk_i),
  .reset_i       (reset_i),
  .instr_valid_i (instr_valid_i),
  .instr_i       (instr_i),
  .wb_valid_o    (wb_valid_o),
  .wb_rd_o       (wb_rd_o),
  .illegal_o     (illegal_o)
);

/* test/rv32_alu_core_tb.sv */
`timescale 1ns/100ps

module rv32_alu_core_tb;
  import rv32_isa_pkg::*;
  import rv32_pipe_pkg::*;

  localparam int reset_cycles = 8;
  localparam int max_instr    = 300;
  // Each instruction takes at most three cycles with its gap
  localparam int timeout_cycles = reset_cycles + 3 * max_instr + pipe_latency + 50;

  logic      clk_i;
  logic      reset_i;
  logic      instr_valid_i;
  word_t     instr_i;
  logic      wb_valid_o;
  reg_addr_t wb_rd_o;
  word_t     wb_data_o;
  logic      illegal_o;

  // Reference model state
  word_t                       model_regs [num_regs];
  logic [reg_bits+xlen-1:0]    exp_q [$];
  logic [reg_bits+xlen-1:0]    head;
  logic [31:0]                 lfsr = 32'h79b3;

  // Expected strobes, driven alongside the instruction and aged like the pipeline
  logic       drv_ill = 1'b0;
  logic       drv_wb = 1'b0;
  logic       ill_exp = 1'b0;
  logic [2:0] wb_pipe = 3'b000;

  int value_errors = 0;
  int protocol_errors = 0;
  int cycle_count = 0;

  rv32_alu_core UUT (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .wb_valid_o    (wb_valid_o),
    .wb_rd_o       (wb_rd_o),
    .wb_data_o     (wb_data_o),
    .illegal_o     (illegal_o)
  );

  always #20 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic word_t enc_r(input logic alt, input reg_addr_t rs2, input reg_addr_t rs1,
                                  input logic [2:0] f3, input reg_addr_t rd);
    return {1'b0, alt, 5'b00000, rs2, rs1, f3, rd, opcode_op};
  endfunction

  function automatic word_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                  input logic [2:0] f3, input reg_addr_t rd);
    return {imm, rs1, f3, rd, opcode_op_imm};
  endfunction

  function automatic word_t enc_u(input logic [19:0] imm, input reg_addr_t rd);
    return {imm, rd, opcode_lui};
  endfunction

  // ISA-level result and legality of one instruction on the model registers
  function automatic void model_eval(input word_t w, output logic legal, output word_t res);
    logic [6:0] opc;
    logic [2:0] f3;
    logic       alt;
    logic       is_op;
    logic       f7_zero;
    word_t      a;
    word_t      b;
    logic [4:0] sh;
    opc     = w[6:0];
    f3      = w[14:12];
    alt     = w[funct7_alt_bit];
    is_op   = (opc == opcode_op);
    f7_zero = ({w[31], w[29:25]} == 6'b0);
    a       = model_regs[w[rs1_lsb +: reg_bits]];
    b       = is_op ? model_regs[w[rs2_lsb +: reg_bits]] : {{20{w[31]}}, w[31:20]};
    sh      = b[4:0];
    res     = '0;
    if (opc == opcode_lui) begin
      legal = 1'b1;
      res   = {w[31:12], 12'h000};
    end else if (is_op) begin
      legal = f7_zero && (!alt || f3 == funct3_add || f3 == funct3_sr);
    end else if (opc == opcode_op_imm) begin
      legal = (f3 == funct3_sll) ? (f7_zero && !alt) : (f3 != funct3_sr || f7_zero);
    end else begin
      legal = 1'b0;
    end
    if (legal && opc != opcode_lui) begin
      case (f3)
        funct3_add:  res = (is_op && alt) ? a - b : a + b;
        funct3_sll:  res = a << sh;
        funct3_slt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        funct3_sltu: res = (a < b) ? 32'd1 : 32'd0;
        funct3_xor:  res = a ^ b;
        funct3_sr:   res = alt ? word_t'($signed(a) >>> sh) : a >> sh;
        funct3_or:   res = a | b;
        default:     res = a & b;
      endcase
    end
  endfunction

  task automatic idle(input int cycles);
    instr_valid_i <= 1'b0;
    drv_ill       <= 1'b0;
    drv_wb        <= 1'b0;
    repeat (cycles) @(posedge clk_i);
  endtask

  // Runs the model, then strobes the instruction for one cycle
  task automatic send(input word_t w, input int gap);
    logic      legal;
    word_t     res;
    reg_addr_t rd;
    model_eval(w, legal, res);
    rd = w[rd_lsb +: reg_bits];
    if (legal && rd != '0) begin
      model_regs[rd] = res;
      exp_q.push_back({rd, res});
    end
    instr_valid_i <= 1'b1;
    instr_i       <= w;
    drv_ill       <= !legal;
    drv_wb        <= legal && rd != '0;
    @(posedge clk_i);
    if (gap > 0) begin
      idle(gap);
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////

  task automatic test_reset_state();
    idle(6);
    for (int r = 1; r < num_regs; r++) begin
      send(enc_i(12'h000, reg_addr_t'(r), funct3_add, reg_addr_t'(r)), 0);
    end
    idle(pipe_latency + 2);
  endtask

  task automatic test_op_imm();
    send(enc_i(12'h7ff, 5'd0, funct3_add, 5'd1), 2);
    send(enc_i(12'hffb, 5'd0, funct3_add, 5'd2), 2);
    send(enc_i(12'hfff, 5'd0, funct3_sltu, 5'd3), 2);
    send(enc_i(12'h000, 5'd2, funct3_slt, 5'd4), 2);
    send(enc_i(12'h0f0, 5'd2, funct3_xor, 5'd5), 2);
    send(enc_i(12'h8a5, 5'd1, funct3_or, 5'd6), 2);
    send(enc_u(20'h80001, 5'd7), 2);
    send(enc_i({7'b0100000, 5'd4}, 5'd7, funct3_sr, 5'd8), 2);
    send(enc_i({7'b0000000, 5'd4}, 5'd7, funct3_sr, 5'd9), 2);
    send(enc_i({7'b0000000, 5'd31}, 5'd1, funct3_sll, 5'd10), pipe_latency + 2);
  endtask

  task automatic test_op();
    send(enc_u(20'h80000, 5'd13), 2);
    send(enc_i(12'hff9, 5'd0, funct3_add, 5'd14), 2);
    send(enc_i(12'd3, 5'd0, funct3_add, 5'd15), 2);
    // Shift amount above 31
    send(enc_i(12'd35, 5'd0, funct3_add, 5'd16), 2);
    send(enc_r(1'b1, 5'd14, 5'd15, funct3_add, 5'd17), 2);
    send(enc_r(1'b1, 5'd15, 5'd14, funct3_sr, 5'd18), 2);
    send(enc_r(1'b1, 5'd16, 5'd13, funct3_sr, 5'd19), 2);
    send(enc_r(1'b0, 5'd16, 5'd13, funct3_sr, 5'd20), 2);
    send(enc_r(1'b0, 5'd15, 5'd14, funct3_slt, 5'd21), 2);
    send(enc_r(1'b0, 5'd15, 5'd14, funct3_sltu, 5'd22), 2);
    send(enc_r(1'b0, 5'd16, 5'd15, funct3_sll, 5'd23), 2);
    send(enc_r(1'b0, 5'd14, 5'd13, funct3_and, 5'd24), pipe_latency + 2);
  endtask

  task automatic test_hazards();
    send(enc_i(12'd5, 5'd0, funct3_add, 5'd1), 0);
    send(enc_i(12'd1, 5'd1, funct3_add, 5'd2), 0);
    send(enc_r(1'b0, 5'd2, 5'd1, funct3_add, 5'd3), 0);
    send(enc_r(1'b1, 5'd3, 5'd1, funct3_add, 5'd4), 0);
    send(enc_i(12'd7, 5'd4, funct3_add, 5'd0), 0);
    send(enc_r(1'b0, 5'd0, 5'd4, funct3_add, 5'd5), 0);
    send(enc_i(12'd100, 5'd0, funct3_add, 5'd6), 0);
    // Immediate field aliases rs2 = x6 and must not be forwarded over
    send(enc_i(12'd6, 5'd0, funct3_add, 5'd7), pipe_latency + 2);
  endtask

  task automatic test_illegal();
    send({12'h000, 5'd0, 3'b010, 5'd1, 7'b0000011}, 0);
    send({7'b0000000, 5'd2, 5'd1, 3'b000, 5'd8, 7'b1100011}, 0);
    send({20'h00100, 5'd1, 7'b1101111}, 0);
    send(enc_r(1'b0, 5'd2, 5'd1, funct3_add, 5'd3) | 32'h0200_0000, 0);
    send(enc_r(1'b1, 5'd2, 5'd1, funct3_xor, 5'd3), 0);
    send(enc_i({7'b0100000, 5'd1}, 5'd1, funct3_sll, 5'd3), 0);
    send(enc_r(1'b0, 5'd3, 5'd1, funct3_or, 5'd9), pipe_latency + 2);
  endtask

  task automatic test_random_stream();
    logic [1:0]  kind;
    logic [2:0]  f3;
    logic        alt;
    logic [11:0] imm;
    reg_addr_t   rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    word_t       w;
    for (int n = 0; n < 200; n++) begin
      kind = 2'(rand_bits(2));
      f3   = 3'(rand_bits(3));
      alt  = 1'(rand_bits(1));
      rd   = reg_addr_t'(rand_bits(5));
      rs1  = reg_addr_t'(rand_bits(5));
      rs2  = reg_addr_t'(rand_bits(5));
      imm  = 12'(rand_bits(12));
      if (f3 == funct3_sll) begin
        imm[11:5] = 7'b0000000;
      end else if (f3 == funct3_sr) begin
        imm[11:5] = {1'b0, alt, 5'b00000};
      end
      case (kind)
        2'd0:    w = enc_u(20'(rand_bits(20)), rd);
        2'd1:    w = enc_i(imm, rs1, f3, rd);
        default: w = enc_r(alt && (f3 == funct3_add || f3 == funct3_sr), rs2, rs1, f3, rd);
      endcase
      send(w, 0);
    end
    idle(pipe_latency + 2);
  endtask

  ////////////////////////////////////////////////////////////////////
  // Response checking
  ////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    ill_exp <= drv_ill;
    wb_pipe <= {wb_pipe[1:0], drv_wb};
  end

  // Outputs settle well before the falling edge
  always @(negedge clk_i) begin
    if (!reset_i) begin
      assert (illegal_o == ill_exp) else begin
        $display("[ERROR] illegal_o: expected %h, got %h", ill_exp, illegal_o);
        value_errors++;
      end
      if (wb_valid_o && wb_pipe[2] && exp_q.size() != 0) begin
        head = exp_q.pop_front();
        assert (wb_rd_o == head[xlen +: reg_bits]) else begin
          $display("[ERROR] wb_rd_o: expected %h, got %h", head[xlen +: reg_bits], wb_rd_o);
          value_errors++;
        end
        assert (wb_data_o == head[xlen-1:0]) else begin
          $display("[ERROR] wb_data_o: expected %h, got %h", head[xlen-1:0], wb_data_o);
          value_errors++;
        end
      end else begin
        assert (!wb_valid_o) else begin
          $display("Writeback to x%0d arrived with no instruction due", wb_rd_o);
          protocol_errors++;
        end
        assert (!wb_pipe[2]) else begin
          $display("An expected writeback did not arrive");
          protocol_errors++;
          if (exp_q.size() != 0) begin
            head = exp_q.pop_front();
          end
        end
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count >= timeout_cycles) begin
      $display("Timeout: run did not finish within %0d cycles", timeout_cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    clk_i         = 1'b0;
    reset_i       = 1'b1;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    for (int i = 0; i < num_regs; i++) begin
      model_regs[i] = '0;
    end
    repeat (reset_cycles) @(posedge clk_i);
    reset_i <= 1'b0;
    test_reset_state();
    test_op_imm();
    test_op();
    test_hazards();
    test_illegal();
    test_random_stream();
    assert (exp_q.size() == 0) else begin
      $display("%0d expected writebacks never arrived", exp_q.size());
      protocol_errors++;
    end
    $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
    if (value_errors + protocol_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
